// File: Makefile
# Verilator build and run for the four-queue packet buffer

VERILATOR ?= verilator
TOP       ?= sram_fifo_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+logic
logic/sram_fifo_pkg.sv
logic/stream_queue_fifo.sv
logic/ingress_arbiter.sv
logic/queue_buffer.sv
logic/egress_arbiter.sv
logic/sram_fifo_top.sv
verif/tb_clock_gen.sv
verif/sram_fifo_tb.sv

// File: logic/egress_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module egress_arbiter (
    input  logic                       clk,
    input  logic                       memreset,
    input  sram_fifo_pkg::queue_mask_t q_nonempty,
    input  sram_fifo_pkg::queue_mask_t out_almost_full,
    output logic                       rd_req,
    output sram_fifo_pkg::queue_id_t   rd_queue
);

    import sram_fifo_pkg::*;

    queue_mask_t eligible;
    queue_id_t   last_q;

    // almost-full keeps a slot free for the read still in flight
    assign eligible = q_nonempty & ~out_almost_full;
    assign rd_req   = |eligible;
    assign rd_queue = rr_pick(eligible, last_q);

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            last_q <= '1;
        end
        else if (rd_req)
        begin
            last_q <= rd_queue;
        end
    end

endmodule

`default_nettype wire

// File: logic/ingress_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

`include "sram_fifo_params.svh"

module ingress_arbiter (
    input  logic                                       clk,
    input  logic                                       memreset,
    input  sram_fifo_pkg::queue_mask_t                 in_nonempty,
    input  sram_fifo_pkg::queue_mask_t                 q_full,
    input  sram_fifo_pkg::beat_t [`SF_NUM_QUEUES-1:0]  head_beats,
    output sram_fifo_pkg::queue_mask_t                 pop,
    output logic                                       wr_valid,
    output sram_fifo_pkg::buf_write_t                  wr
);

    import sram_fifo_pkg::*;

    queue_mask_t eligible;
    queue_id_t   last_q;
    queue_id_t   grant_q;

    // needs a beat waiting and room in its region
    assign eligible = in_nonempty & ~q_full;
    assign grant_q  = rr_pick(eligible, last_q);
    assign wr_valid = |eligible;

    always_comb
    begin
        pop          = '0;
        pop[grant_q] = wr_valid;
        wr.queue     = grant_q;
        wr.beat      = head_beats[grant_q];
    end

    // queue 0 goes first after reset
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            last_q <= '1;
        end
        else if (wr_valid)
        begin
            last_q <= grant_q;
        end
    end

    // the popped FIFO must hold a beat and have room in its region
    a_pop_eligible: assert property (@(posedge clk) disable iff (memreset)
        (pop & ~eligible) == '0);

endmodule

`default_nettype wire

// File: logic/queue_buffer.sv
`default_nettype none
`timescale 1ns/100ps

`include "sram_fifo_params.svh"

module queue_buffer (
    input  logic                       clk,
    input  logic                       memreset,
    input  logic                       wr_valid,
    input  sram_fifo_pkg::buf_write_t  wr,
    input  logic                       rd_req,
    input  sram_fifo_pkg::queue_id_t   rd_queue,
    output logic                       rd_valid,
    output sram_fifo_pkg::buf_read_t   rd,
    output sram_fifo_pkg::queue_mask_t q_full,
    output sram_fifo_pkg::queue_mask_t q_nonempty
);

    import sram_fifo_pkg::*;

    localparam int slot_bits = $clog2(`SF_QUEUE_SLOTS);

    typedef logic [slot_bits-1:0] slot_idx_t;
    typedef logic [slot_bits:0]   count_t;

    ////////////////////////////////////////////////////////////
    // shared memory, one region of SF_QUEUE_SLOTS per queue
    ////////////////////////////////////////////////////////////

    beat_t mem [`SF_NUM_QUEUES*`SF_QUEUE_SLOTS];

    slot_idx_t head  [`SF_NUM_QUEUES];
    slot_idx_t tail  [`SF_NUM_QUEUES];
    count_t    count [`SF_NUM_QUEUES];

    slot_addr_t  wr_addr;
    slot_addr_t  rd_addr;
    queue_mask_t wr_hit;
    queue_mask_t rd_hit;

    // region base is the queue id in the upper address bits
    assign wr_addr = {wr.queue, tail[wr.queue]};
    assign rd_addr = {rd_queue, head[rd_queue]};

    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            mem[wr_addr] <= wr.beat;
        end
        if (rd_req)
        begin
            rd.beat  <= mem[rd_addr];
            rd.queue <= rd_queue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_req;
        end
    end

    ////////////////////////////////////////////////////////////
    // per-queue head, tail and count
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        wr_hit           = '0;
        rd_hit           = '0;
        wr_hit[wr.queue] = wr_valid;
        rd_hit[rd_queue] = rd_req;
    end

    // write and read on one queue in the same cycle leave count unchanged
    always_ff @(posedge clk)
    begin
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            if (memreset)
            begin
                head[q]  <= '0;
                tail[q]  <= '0;
                count[q] <= '0;
            end
            else
            begin
                if (wr_hit[q])
                begin
                    tail[q] <= slot_idx_t'(tail[q] + 1);
                end
                if (rd_hit[q])
                begin
                    head[q] <= slot_idx_t'(head[q] + 1);
                end
                case ({wr_hit[q], rd_hit[q]})
                    2'b10:   count[q] <= count_t'(count[q] + 1);
                    2'b01:   count[q] <= count_t'(count[q] - 1);
                    default: count[q] <= count[q];
                endcase
            end
        end
    end

    always_comb
    begin
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            q_full[q]     = (count[q] == count_t'(`SF_QUEUE_SLOTS));
            q_nonempty[q] = (count[q] != '0);
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (memreset)
        wr_valid |-> !q_full[wr.queue]);
    a_no_read_empty: assert property (@(posedge clk) disable iff (memreset)
        rd_req |-> q_nonempty[rd_queue]);

endmodule

`default_nettype wire

// File: logic/sram_fifo_params.svh
`ifndef SRAM_FIFO_PARAMS_SVH
`define SRAM_FIFO_PARAMS_SVH

// queues in and out, one buffer region each
`define SF_NUM_QUEUES 4

// stream beat fields
`define SF_DATA_WIDTH 64
`define SF_USER_WIDTH 4

// entries per input and output FIFO
`define SF_FIFO_DEPTH 8

// entries per queue region in the shared buffer
`define SF_QUEUE_SLOTS 16

`endif

// File: logic/sram_fifo_pkg.sv
`default_nettype none

`include "sram_fifo_params.svh"

package sram_fifo_pkg;

    typedef logic [$clog2(`SF_NUM_QUEUES)-1:0] queue_id_t;
    typedef logic [`SF_NUM_QUEUES-1:0] queue_mask_t;
    typedef logic [$clog2(`SF_NUM_QUEUES*`SF_QUEUE_SLOTS)-1:0] slot_addr_t;

    // one stream beat
    typedef struct packed {
        logic [`SF_DATA_WIDTH-1:0] data;
        logic [`SF_USER_WIDTH-1:0] user;
        logic                      last;
    } beat_t;

    typedef struct packed {
        queue_id_t queue;
        beat_t     beat;
    } buf_write_t;

    typedef struct packed {
        queue_id_t queue;
        beat_t     beat;
    } buf_read_t;

    // round-robin pick, nearest eligible queue after last winner
    function automatic queue_id_t rr_pick(input queue_mask_t eligible, input queue_id_t last);
        queue_id_t pick;
        int        idx;
        pick = last;
        // walk from farthest to nearest so the nearest hit wins
        for (int k = `SF_NUM_QUEUES; k >= 1; k--)
        begin
            idx = (int'(last) + k) % `SF_NUM_QUEUES;
            if (eligible[idx])
            begin
                pick = queue_id_t'(idx);
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

// File: logic/sram_fifo_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "sram_fifo_params.svh"

module sram_fifo_top (
    input  logic                                      clk,
    input  logic                                      memreset,
    input  sram_fifo_pkg::beat_t [`SF_NUM_QUEUES-1:0] in_beat,
    input  sram_fifo_pkg::queue_mask_t                in_valid,
    output sram_fifo_pkg::queue_mask_t                in_ready,
    output sram_fifo_pkg::beat_t [`SF_NUM_QUEUES-1:0] out_beat,
    output sram_fifo_pkg::queue_mask_t                out_valid,
    input  sram_fifo_pkg::queue_mask_t                out_ready
);

    import sram_fifo_pkg::*;

    beat_t [`SF_NUM_QUEUES-1:0] head_beats;

    queue_mask_t in_full;
    queue_mask_t in_empty;
    queue_mask_t in_nonempty;
    queue_mask_t in_pop;
    queue_mask_t q_full;
    queue_mask_t q_nonempty;
    queue_mask_t out_almost_full;
    queue_mask_t out_empty;
    queue_mask_t out_push;

    logic       wr_valid;
    buf_write_t wr;
    logic       rd_req;
    queue_id_t  rd_queue;
    logic       rd_valid;
    buf_read_t  rd;

    ////////////////////////////////////////////////////////////
    // per-queue input and output FIFOs
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SF_NUM_QUEUES; i++)
    begin : g_queue
        assign in_ready[i]    = ~in_full[i];
        assign in_nonempty[i] = ~in_empty[i];
        assign out_valid[i]   = ~out_empty[i];
        // returned read data steered by its queue id
        assign out_push[i]    = rd_valid && (rd.queue == queue_id_t'(i));

        stream_queue_fifo #(.depth(`SF_FIFO_DEPTH)) u_in_fifo (
            .clk         (clk),
            .memreset    (memreset),
            .push        (in_valid[i] & in_ready[i]),
            .push_beat   (in_beat[i]),
            .pop         (in_pop[i]),
            .head_beat   (head_beats[i]),
            .full        (in_full[i]),
            .almost_full (),
            .empty       (in_empty[i])
        );

        stream_queue_fifo #(.depth(`SF_FIFO_DEPTH)) u_out_fifo (
            .clk         (clk),
            .memreset    (memreset),
            .push        (out_push[i]),
            .push_beat   (rd.beat),
            .pop         (out_valid[i] & out_ready[i]),
            .head_beat   (out_beat[i]),
            .full        (),
            .almost_full (out_almost_full[i]),
            .empty       (out_empty[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // arbiters around the shared buffer
    ////////////////////////////////////////////////////////////

    ingress_arbiter u_ingress (
        .clk         (clk),
        .memreset    (memreset),
        .in_nonempty (in_nonempty),
        .q_full      (q_full),
        .head_beats  (head_beats),
        .pop         (in_pop),
        .wr_valid    (wr_valid),
        .wr          (wr)
    );

    queue_buffer u_buffer (
        .clk        (clk),
        .memreset   (memreset),
        .wr_valid   (wr_valid),
        .wr         (wr),
        .rd_req     (rd_req),
        .rd_queue   (rd_queue),
        .rd_valid   (rd_valid),
        .rd         (rd),
        .q_full     (q_full),
        .q_nonempty (q_nonempty)
    );

    egress_arbiter u_egress (
        .clk             (clk),
        .memreset        (memreset),
        .q_nonempty      (q_nonempty),
        .out_almost_full (out_almost_full),
        .rd_req          (rd_req),
        .rd_queue        (rd_queue)
    );

endmodule

`default_nettype wire

// File: logic/stream_queue_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "sram_fifo_params.svh"

module stream_queue_fifo #(
    parameter int depth = `SF_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 memreset,
    input  logic                 push,
    input  sram_fifo_pkg::beat_t push_beat,
    input  logic                 pop,
    output sram_fifo_pkg::beat_t head_beat,
    output logic                 full,
    output logic                 almost_full,
    output logic                 empty
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

    typedef logic [ptr_bits-1:0] ptr_t;
    typedef logic [ptr_bits:0]   count_t;

    sram_fifo_pkg::beat_t store [depth];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    // payload storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            store[wr_ptr] <= push_beat;
        end
    end

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : ptr_t'(wr_ptr + 1);
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : ptr_t'(rd_ptr + 1);
            end
            if (push && !pop)
            begin
                count <= count_t'(count + 1);
            end
            else if (pop && !push)
            begin
                count <= count_t'(count - 1);
            end
        end
    end

    assign head_beat   = store[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == count_t'(depth));
    // one slot of slack for a read already on its way
    assign almost_full = (count >= count_t'(depth - 1));

    a_no_push_full: assert property (@(posedge clk) disable iff (memreset) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (memreset) pop |-> !empty);

endmodule

`default_nettype wire

// File: verif/sram_fifo_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "sram_fifo_params.svh"

module sram_fifo_tb;

    import sram_fifo_pkg::*;

    localparam int reset_cycles  = 16;
    localparam int drain_limit   = 2000;
    localparam int settle_cycles = 10;
    localparam int stall_streak  = 20;

    logic                       clk;
    logic                       memreset;
    beat_t [`SF_NUM_QUEUES-1:0] in_beat;
    queue_mask_t                in_valid;
    queue_mask_t                in_ready;
    beat_t [`SF_NUM_QUEUES-1:0] out_beat;
    queue_mask_t                out_valid;
    queue_mask_t                out_ready;

    int          seed;
    beat_t       send_q   [`SF_NUM_QUEUES][$];
    beat_t       expect_q [`SF_NUM_QUEUES][$];
    int          accepted [`SF_NUM_QUEUES];
    queue_mask_t ready_mask;
    logic        random_stall;

    tb_clock_gen #(.period_ns(40)) u_clk (.clk(clk));

    sram_fifo_top dut (
        .clk       (clk),
        .memreset  (memreset),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    ////////////////////////////////////////////////////////////
    // error handling and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_beat(input beat_t got, input beat_t exp, input queue_id_t q);
        if (got !== exp)
        begin
            stop_run($sformatf("MISMATCH at %0t: queue %0d got %h/%h/%b expected %h/%h/%b",
                $time, q, got.data, got.user, got.last, exp.data, exp.user, exp.last));
        end
    endtask

    task automatic compare_mask(input queue_mask_t got, input queue_mask_t exp,
                                input string what);
        if (got !== exp)
        begin
            stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and per-cycle scoreboard
    ////////////////////////////////////////////////////////////

    task automatic load_queue(input int q, input int n);
        beat_t b;
        for (int k = 0; k < n; k++)
        begin
            b.data = {$random(seed), $random(seed)};
            b.user = `SF_USER_WIDTH'($random(seed));
            b.last = (k == n - 1);
            send_q[q].push_back(b);
        end
    endtask

    function automatic logic all_empty();
        logic done;
        done = 1'b1;
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            if (send_q[i].size() != 0 || expect_q[i].size() != 0)
            begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // drive on the falling edge, then record what the next rising edge moves
    task automatic step();
        beat_t exp;
        @(negedge clk);
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            in_valid[i] = (send_q[i].size() > 0);
            if (in_valid[i])
            begin
                in_beat[i] = send_q[i][0];
            end
            else
            begin
                in_beat[i] = '0;
            end
        end
        out_ready = random_stall ? queue_mask_t'($random(seed)) : ready_mask;
        #1;
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            if (in_valid[i] && in_ready[i])
            begin
                expect_q[i].push_back(send_q[i].pop_front());
                accepted[i]++;
            end
            if (out_valid[i] && out_ready[i])
            begin
                if (expect_q[i].size() == 0)
                begin
                    stop_run($sformatf("output %0d delivered a beat that was never sent, at %0t",
                        i, $time));
                end
                else
                begin
                    exp = expect_q[i].pop_front();
                    check_beat(out_beat[i], exp, queue_id_t'(i));
                end
            end
        end
    endtask

    task automatic drain_all(input string name);
        int cycles;
        cycles = 0;
        while (!all_empty())
        begin
            step();
            cycles++;
            if (cycles > drain_limit)
            begin
                stop_run($sformatf("%s: beats still missing after %0d cycles", name, cycles));
            end
        end
        // watch a little longer for extra beats
        repeat (settle_cycles) step();
        // nothing may be left waiting in any output FIFO
        compare_mask(out_valid, '0, $sformatf("%s: out_valid after drain", name));
    endtask

    task automatic apply_reset();
        memreset = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        memreset = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        @(negedge clk);
        #1;
        compare_mask(out_valid, '0, "out_valid after reset");
        compare_mask(in_ready, '1, "in_ready after reset");
    endtask

    task automatic single_queue_packet();
        random_stall = 1'b0;
        ready_mask   = '1;
        load_queue(2, 10);
        drain_all("single queue");
    endtask

    task automatic all_queues_at_once();
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            load_queue(i, 24);
        end
        drain_all("all queues");
    endtask

    task automatic queue1_back_pressure();
        int low_cycles;
        int cycles;
        int max_beats;
        max_beats     = 2 * `SF_FIFO_DEPTH + `SF_QUEUE_SLOTS;
        ready_mask    = '1;
        ready_mask[1] = 1'b0;
        accepted[1]   = 0;
        load_queue(1, max_beats + 20);
        load_queue(3, 20);
        low_cycles = 0;
        cycles     = 0;
        // queue 3 must drain while queue 1 is blocked
        while (send_q[3].size() != 0 || expect_q[3].size() != 0 || low_cycles < stall_streak)
        begin
            step();
            low_cycles = in_ready[1] ? 0 : low_cycles + 1;
            cycles++;
            if (cycles > drain_limit)
            begin
                stop_run("back-pressure: queue 3 stuck or in_ready[1] never stayed low");
            end
        end
        if (accepted[1] < `SF_FIFO_DEPTH || accepted[1] > max_beats)
        begin
            stop_run($sformatf("back-pressure: queue 1 took %0d beats, allowed %0d to %0d",
                accepted[1], `SF_FIFO_DEPTH, max_beats));
        end
        ready_mask[1] = 1'b1;
        drain_all("back-pressure release");
    endtask

    task automatic random_output_stalls();
        random_stall = 1'b1;
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            load_queue(i, 30);
        end
        drain_all("random stalls");
        random_stall = 1'b0;
    endtask

    initial
    begin
        seed         = 6284;
        memreset     = 1'b1;
        in_beat      = '0;
        in_valid     = '0;
        out_ready    = '0;
        ready_mask   = '1;
        random_stall = 1'b0;
        for (int i = 0; i < `SF_NUM_QUEUES; i++)
        begin
            accepted[i] = 0;
        end
        apply_reset();
        idle_after_reset();
        single_queue_packet();
        all_queues_at_once();
        queue1_back_pressure();
        random_output_stalls();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    // free-running, starts low
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
